/* source/geometry_pkg.sv */
`default_nettype none

package geometry_pkg;

    typedef logic signed [31:0] q16_16_t;
    typedef logic signed [63:0] q32_32_t;

    typedef struct packed {
        q16_16_t x;
        q16_16_t y;
        q16_16_t z;
    } vec3_t;

    typedef struct packed {
        vec3_t       pos;
        logic [23:0] color;
    } vertex_t;

    typedef struct packed {
        vertex_t v0;
        vertex_t v1;
        vertex_t v2;
    } triangle_t;

    // Row-major 2x3 affine matrix.
    typedef struct packed {
        q16_16_t m00;
        q16_16_t m01;
        q16_16_t tx;
        q16_16_t m10;
        q16_16_t m11;
        q16_16_t ty;
    } affine_t;

    typedef struct packed {
        logic        cyc;
        logic        stb;
        logic        we;
        logic [2:0]  adr;
        logic [31:0] dat;
    } wb_req_t;

    typedef struct packed {
        logic [31:0] dat;
        logic        ack;
    } wb_rsp_t;

    localparam int SCREEN_WIDTH  = 320;
    localparam int SCREEN_HEIGHT = 240;
    localparam int NORM_SCALE    = 200;
    localparam int HALF_WIDTH    = SCREEN_WIDTH / 2;
    localparam int HALF_HEIGHT   = SCREEN_HEIGHT / 2;
    localparam q16_16_t NORM_FACTOR = q16_16_t'((HALF_HEIGHT << 16) / NORM_SCALE);

    localparam logic [2:0] REG_CULL_COUNT = 3'd6;

    // Q16.16 multiply rounded half up on bit 15.
    function automatic q16_16_t q_mul(input q16_16_t a, input q16_16_t b);
        q32_32_t prod;
        prod = q32_32_t'(a) * q32_32_t'(b);
        prod = prod + q32_32_t'(1 << 15);
        return q16_16_t'(prod >>> 16);
    endfunction

endpackage

`default_nettype wire

/* source/transform_regs.sv */
`default_nettype none
`timescale 1ns/100ps

module transform_regs (
    input  wire logic                 clk,
    input  wire logic                 rst,
    input  wire geometry_pkg::wb_req_t wb_req,
    output      geometry_pkg::wb_rsp_t wb_rsp,
    output      geometry_pkg::affine_t matrix,
    input  wire logic                 cull_pulse
);

    localparam geometry_pkg::q16_16_t ONE = 32'sh0001_0000;

    geometry_pkg::affine_t matrix_r;
    logic [15:0]           cull_count;
    logic                  ack_r;
    logic [31:0]           rd_dat_r;
    logic [31:0]           rd_dat;
    logic                  access;

    assign access = wb_req.cyc && wb_req.stb && !ack_r;

    always_comb begin
        case (wb_req.adr)
            3'd0:                         rd_dat = matrix_r.m00;
            3'd1:                         rd_dat = matrix_r.m01;
            3'd2:                         rd_dat = matrix_r.tx;
            3'd3:                         rd_dat = matrix_r.m10;
            3'd4:                         rd_dat = matrix_r.m11;
            3'd5:                         rd_dat = matrix_r.ty;
            geometry_pkg::REG_CULL_COUNT: rd_dat = {16'h0000, cull_count};
            default:                      rd_dat = 32'h0000_0000;
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            ack_r         <= 1'b0;
            matrix_r      <= '0;
            matrix_r.m00  <= ONE; // Identity.
            matrix_r.m11  <= ONE;
        end else begin
            ack_r <= access;
            if (access && wb_req.we) begin
                case (wb_req.adr)
                    3'd0:    matrix_r.m00 <= wb_req.dat;
                    3'd1:    matrix_r.m01 <= wb_req.dat;
                    3'd2:    matrix_r.tx  <= wb_req.dat;
                    3'd3:    matrix_r.m10 <= wb_req.dat;
                    3'd4:    matrix_r.m11 <= wb_req.dat;
                    3'd5:    matrix_r.ty  <= wb_req.dat;
                    default: ; // Count and address 7 are read only.
                endcase
            end
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cull_count <= 16'h0000;
        end else if (cull_pulse) begin
            cull_count <= cull_count + 16'h0001; // Wraps.
        end
    end

    always_ff @(posedge clk) begin
        if (access) begin
            rd_dat_r <= rd_dat;
        end
    end

    assign wb_rsp.ack = ack_r;
    assign wb_rsp.dat = rd_dat_r;
    assign matrix     = matrix_r;

endmodule

`default_nettype wire

/* source/triangle_transformer.sv */
`default_nettype none
`timescale 1ns/100ps

module triangle_transformer (
    input  wire logic                   clk,
    input  wire logic                   rst,

    input  wire geometry_pkg::affine_t   matrix,

    input  wire geometry_pkg::triangle_t in_triangle,
    input  wire logic                   in_valid,
    output      logic                   in_ready,

    output      geometry_pkg::triangle_t out_triangle,
    output      logic                   out_valid,
    input  wire logic                   out_ready,

    output      logic                   busy
);

    // Applies the 2x3 matrix to one vertex.
    function automatic geometry_pkg::vertex_t xform_vertex(
        input geometry_pkg::vertex_t vin,
        input geometry_pkg::affine_t m
    );
        geometry_pkg::vertex_t vout;
        vout       = vin; // Z and colour kept.
        vout.pos.x = geometry_pkg::q_mul(m.m00, vin.pos.x)
                   + geometry_pkg::q_mul(m.m01, vin.pos.y)
                   + m.tx;
        vout.pos.y = geometry_pkg::q_mul(m.m10, vin.pos.x)
                   + geometry_pkg::q_mul(m.m11, vin.pos.y)
                   + m.ty;
        return vout;
    endfunction

    function automatic geometry_pkg::triangle_t xform_triangle(
        input geometry_pkg::triangle_t tin,
        input geometry_pkg::affine_t   m
    );
        geometry_pkg::triangle_t tout;
        tout.v0 = xform_vertex(tin.v0, m);
        tout.v1 = xform_vertex(tin.v1, m);
        tout.v2 = xform_vertex(tin.v2, m);
        return tout;
    endfunction

    geometry_pkg::triangle_t out_triangle_r;
    logic                    out_valid_r;

    assign in_ready = !out_valid_r || out_ready;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            out_valid_r <= 1'b0;
        end else if (in_ready) begin
            out_valid_r <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (in_ready) begin
            out_triangle_r <= xform_triangle(in_triangle, matrix);
        end
    end

    assign out_triangle = out_triangle_r;
    assign out_valid    = out_valid_r;
    assign busy         = out_valid_r;

endmodule

`default_nettype wire

/* source/screen_normalizer.sv */
`default_nettype none
`timescale 1ns/100ps

module screen_normalizer (
    input  wire logic                   clk,
    input  wire logic                   rst,

    input  wire geometry_pkg::triangle_t in_triangle,
    input  wire logic                   in_valid,
    output      logic                   in_ready,

    output      geometry_pkg::triangle_t out_triangle,
    output      logic                   out_valid,
    input  wire logic                   out_ready,

    output      logic                   busy
);

    localparam geometry_pkg::q16_16_t X_OFFSET =
        geometry_pkg::q16_16_t'(geometry_pkg::HALF_WIDTH << 16);
    localparam geometry_pkg::q16_16_t Y_OFFSET =
        geometry_pkg::q16_16_t'(geometry_pkg::HALF_HEIGHT << 16);

    // Y is negated so that screen rows grow downward.
    function automatic geometry_pkg::vertex_t norm_vertex(input geometry_pkg::vertex_t vin);
        geometry_pkg::vertex_t vout;
        vout       = vin;
        vout.pos.x = geometry_pkg::q_mul(vin.pos.x, geometry_pkg::NORM_FACTOR) + X_OFFSET;
        vout.pos.y = geometry_pkg::q_mul(-vin.pos.y, geometry_pkg::NORM_FACTOR) + Y_OFFSET;
        return vout;
    endfunction

    geometry_pkg::triangle_t out_triangle_r;
    logic                    out_valid_r;

    assign in_ready = !out_valid_r || out_ready;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            out_valid_r <= 1'b0;
        end else if (in_ready) begin
            out_valid_r <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (in_ready) begin
            out_triangle_r.v0 <= norm_vertex(in_triangle.v0);
            out_triangle_r.v1 <= norm_vertex(in_triangle.v1);
            out_triangle_r.v2 <= norm_vertex(in_triangle.v2);
        end
    end

    assign out_triangle = out_triangle_r;
    assign out_valid    = out_valid_r;
    assign busy         = out_valid_r;

endmodule

`default_nettype wire

/* source/backface_culler.sv */
`default_nettype none
`timescale 1ns/100ps

module backface_culler (
    input  wire logic                   clk,
    input  wire logic                   rst,

    input  wire geometry_pkg::triangle_t in_triangle,
    input  wire logic                   in_valid,
    output      logic                   in_ready,

    output      geometry_pkg::triangle_t out_triangle,
    output      logic                   out_valid,
    input  wire logic                   out_ready,

    output      logic                   busy,
    output      logic                   cull_pulse
);

    logic signed [15:0] x0, y0, x1, y1, x2, y2;
    logic signed [16:0] dx1, dy1, dx2, dy2;
    logic signed [34:0] area2;
    logic               front;

    // Integer pixel parts only.
    assign x0 = in_triangle.v0.pos.x[31:16];
    assign y0 = in_triangle.v0.pos.y[31:16];
    assign x1 = in_triangle.v1.pos.x[31:16];
    assign y1 = in_triangle.v1.pos.y[31:16];
    assign x2 = in_triangle.v2.pos.x[31:16];
    assign y2 = in_triangle.v2.pos.y[31:16];

    assign dx1 = 17'(x1) - 17'(x0);
    assign dy1 = 17'(y1) - 17'(y0);
    assign dx2 = 17'(x2) - 17'(x0);
    assign dy2 = 17'(y2) - 17'(y0);

    // Twice the signed area. Zero covers degenerate triangles.
    assign area2 = 35'(dx1) * 35'(dy2) - 35'(dx2) * 35'(dy1);
    assign front = area2 > 35'sd0;

    geometry_pkg::triangle_t out_triangle_r;
    logic                    out_valid_r;
    logic                    cull_pulse_r;

    assign in_ready = !out_valid_r || out_ready;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            out_valid_r  <= 1'b0;
            cull_pulse_r <= 1'b0;
        end else begin
            cull_pulse_r <= in_valid && in_ready && !front;
            if (in_ready) begin
                out_valid_r <= in_valid && front;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (in_ready) begin
            out_triangle_r <= in_triangle;
        end
    end

    assign out_triangle = out_triangle_r;
    assign out_valid    = out_valid_r;
    assign cull_pulse   = cull_pulse_r;
    assign busy         = out_valid_r || cull_pulse_r; // Count not yet updated.

endmodule

`default_nettype wire

/* source/geometry_pipeline.sv */
`default_nettype none
`timescale 1ns/100ps

module geometry_pipeline (
    input  wire logic                   clk,
    input  wire logic                   rst,

    input  wire geometry_pkg::triangle_t in_triangle,
    input  wire logic                   in_valid,
    output      logic                   in_ready,

    output      geometry_pkg::triangle_t out_triangle,
    output      logic                   out_valid,
    input  wire logic                   out_ready,

    input  wire geometry_pkg::wb_req_t   wb_req,
    output      geometry_pkg::wb_rsp_t   wb_rsp,

    output      logic                   busy
);

    geometry_pkg::affine_t   matrix;
    geometry_pkg::triangle_t xf_triangle;
    geometry_pkg::triangle_t nm_triangle;
    logic                    xf_valid, xf_ready, xf_busy;
    logic                    nm_valid, nm_ready, nm_busy;
    logic                    cl_busy;
    logic                    cull_pulse;

    transform_regs i_transform_regs (
        .clk        (clk),
        .rst        (rst),
        .wb_req     (wb_req),
        .wb_rsp     (wb_rsp),
        .matrix     (matrix),
        .cull_pulse (cull_pulse)
    );

    triangle_transformer i_triangle_transformer (
        .clk          (clk),
        .rst          (rst),
        .matrix       (matrix),
        .in_triangle  (in_triangle),
        .in_valid     (in_valid),
        .in_ready     (in_ready),
        .out_triangle (xf_triangle),
        .out_valid    (xf_valid),
        .out_ready    (xf_ready),
        .busy         (xf_busy)
    );

    screen_normalizer i_screen_normalizer (
        .clk          (clk),
        .rst          (rst),
        .in_triangle  (xf_triangle),
        .in_valid     (xf_valid),
        .in_ready     (xf_ready),
        .out_triangle (nm_triangle),
        .out_valid    (nm_valid),
        .out_ready    (nm_ready),
        .busy         (nm_busy)
    );

    backface_culler i_backface_culler (
        .clk          (clk),
        .rst          (rst),
        .in_triangle  (nm_triangle),
        .in_valid     (nm_valid),
        .in_ready     (nm_ready),
        .out_triangle (out_triangle),
        .out_valid    (out_valid),
        .out_ready    (out_ready),
        .busy         (cl_busy),
        .cull_pulse   (cull_pulse)
    );

    assign busy = xf_busy || nm_busy || cl_busy;

endmodule

`default_nettype wire

/* test/geometry_model.svh */
`ifndef GEOMETRY_MODEL_SVH
`define GEOMETRY_MODEL_SVH

// Widen, add half an LSB, shift, truncate.
function automatic geometry_pkg::q16_16_t round_mul(input geometry_pkg::q16_16_t a,
                                                    input geometry_pkg::q16_16_t b);
    longint wide;
    wide = longint'(a) * longint'(b) + 64'sd32768;
    return geometry_pkg::q16_16_t'(wide >>> 16);
endfunction

function automatic geometry_pkg::triangle_t model_transform(
    input geometry_pkg::triangle_t t,
    input geometry_pkg::affine_t   m
);
    geometry_pkg::vertex_t v[3];
    geometry_pkg::q16_16_t x;
    geometry_pkg::q16_16_t y;
    v[0] = t.v0;
    v[1] = t.v1;
    v[2] = t.v2;
    for (int i = 0; i < 3; i++) begin
        x = v[i].pos.x;
        y = v[i].pos.y;
        v[i].pos.x = round_mul(m.m00, x) + round_mul(m.m01, y) + m.tx;
        v[i].pos.y = round_mul(m.m10, x) + round_mul(m.m11, y) + m.ty;
    end
    return {v[0], v[1], v[2]};
endfunction

// Pixel coordinates with rows counted downward.
function automatic geometry_pkg::triangle_t model_normalize(input geometry_pkg::triangle_t t);
    int                    half_w;
    int                    half_h;
    int                    factor;
    geometry_pkg::vertex_t v[3];
    half_w = geometry_pkg::SCREEN_WIDTH / 2;
    half_h = geometry_pkg::SCREEN_HEIGHT / 2;
    factor = (half_h << 16) / geometry_pkg::NORM_SCALE;
    v[0] = t.v0;
    v[1] = t.v1;
    v[2] = t.v2;
    for (int i = 0; i < 3; i++) begin
        v[i].pos.x = round_mul(v[i].pos.x, factor) + (half_w << 16);
        v[i].pos.y = round_mul(-v[i].pos.y, factor) + (half_h << 16);
    end
    return {v[0], v[1], v[2]};
endfunction

// Twice the signed area over the integer pixel parts.
function automatic bit model_is_front(input geometry_pkg::triangle_t t);
    longint                x[3];
    longint                y[3];
    geometry_pkg::vertex_t v[3];
    v[0] = t.v0;
    v[1] = t.v1;
    v[2] = t.v2;
    for (int i = 0; i < 3; i++) begin
        x[i] = longint'($signed(v[i].pos.x[31:16]));
        y[i] = longint'($signed(v[i].pos.y[31:16]));
    end
    return (x[1] - x[0]) * (y[2] - y[0]) - (x[2] - x[0]) * (y[1] - y[0]) > 0;
endfunction

`endif

/* test/geometry_pipeline_tb.sv */
`default_nettype none
`timescale 1ns/100ps

module geometry_pipeline_tb;

    localparam int TIMEOUT = 1000;

    logic                    clk;
    logic                    rst;
    logic                    in_valid;
    logic                    in_ready;
    logic                    out_valid;
    logic                    out_ready;
    logic                    busy;
    geometry_pkg::triangle_t in_triangle;
    geometry_pkg::triangle_t out_triangle;
    geometry_pkg::wb_req_t   wb_req;
    geometry_pkg::wb_rsp_t   wb_rsp;

    bit [31:0]               seed = 32'h5a7e;
    geometry_pkg::affine_t   cur_matrix;
    geometry_pkg::triangle_t exp_q[$];
    int                      accept_q[$];
    int                      out_cycles[$];
    int                      cycle, accepted, issued, pushed, delivered, exp_culls;
    int                      errors, checks, tests, test_errors;
    bit                      check_latency;

    geometry_pipeline i_geometry_pipeline (.*);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    task automatic check_value(input string name, input logic [359:0] got,
                               input logic [359:0] expected);
        checks++;
        if (got !== expected) begin
            $display("ERR %s: got %0h, expected %0h", name, got, expected);
            errors++;
        end
    endtask

    task automatic abort_run(input string why);
        $display("Timeout: %s", why);
        $display("STATUS: FAIL");
        $finish;
    endtask

    task automatic finish_test(input string name);
        tests++;
        $display("test %0d %s: %s", tests, name, errors == test_errors ? "ok" : "failed");
        test_errors = errors;
    endtask

    function automatic bit [31:0] xorshift_next();
        seed = seed ^ (seed << 13);
        seed = seed ^ (seed >> 17);
        seed = seed ^ (seed << 5);
        return seed;
    endfunction

    // Uniform in [-lim, lim].
    function automatic geometry_pkg::q16_16_t draw_fixed(input int lim);
        return int'(xorshift_next() % (2 * lim + 1)) - lim;
    endfunction

    function automatic geometry_pkg::triangle_t make_triangle(input bit front_only,
                                                              input bit degenerate);
        geometry_pkg::triangle_t t;
        geometry_pkg::vertex_t   v[3];
        for (int tries = 0; tries < 64; tries++) begin
            for (int i = 0; i < 3; i++) begin
                v[i].pos.x = draw_fixed(98304); // Within 1.5.
                v[i].pos.y = draw_fixed(98304);
                v[i].pos.z = xorshift_next();
                v[i].color = 24'(xorshift_next());
            end
            if (degenerate && xorshift_next() % 10 == 0) begin
                v[1] = v[0]; // Collapsed to a point.
                v[2] = v[0];
            end
            t = {v[0], v[1], v[2]};
            if (!front_only ||
                    model_is_front(model_normalize(model_transform(t, cur_matrix)))) begin
                break;
            end
        end
        return t;
    endfunction

    // Ack must follow one edge after the request and last one cycle.
    task automatic wb_access(input bit we, input bit [2:0] adr, input bit [31:0] wdat,
                             output bit [31:0] rdat);
        int n;
        wb_req = '{cyc: 1'b1, stb: 1'b1, we: we, adr: adr, dat: wdat};
        n = 0;
        do begin
            @(negedge clk);
            n++;
        end while (!wb_rsp.ack && n < TIMEOUT);
        rdat = wb_rsp.dat;
        if (!wb_rsp.ack) begin
            abort_run("no Wishbone acknowledge");
        end else begin
            check_value("wb_rsp.ack delay", n, 1);
            wb_req = '0;
            @(negedge clk);
            check_value("wb_rsp.ack", wb_rsp.ack, 0);
        end
    endtask

    task automatic load_matrix(input geometry_pkg::affine_t m);
        bit [31:0] rdat;
        for (int a = 0; a < 6; a++) begin
            wb_access(1'b1, 3'(a), m[(5 - a) * 32 +: 32], rdat);
        end
        cur_matrix = m;
    endtask

    task automatic send_triangles(input int count, input int valid_pct, input int ready_pct,
                                  input bit front_only, input bit degenerate);
        int target;
        int n;
        target = accepted + count;
        n = 0;
        while (accepted < target && n < 100 * count + TIMEOUT) begin
            @(negedge clk);
            n++;
            out_ready = xorshift_next() % 100 < ready_pct;
            if (accepted == issued) begin // Previous one taken.
                in_valid = issued < target && xorshift_next() % 100 < valid_pct;
                if (in_valid) begin
                    in_triangle = make_triangle(front_only, degenerate);
                    issued++;
                end
            end
        end
        in_valid = 1'b0;
        out_ready = 1'b1;
        if (accepted < target) abort_run("triangle stream stalled");
    endtask

    task automatic wait_drain();
        int n;
        n = 0;
        while ((busy || exp_q.size() != 0) && n < TIMEOUT) begin
            @(negedge clk);
            n++;
        end
        if (busy || exp_q.size() != 0) abort_run("pipeline did not drain");
    endtask

    always @(posedge clk) begin : scoreboard
        geometry_pkg::triangle_t t;
        int                      lat;
        cycle++;
        if (!rst && exp_q.size() != 0) begin
            check_value("busy", busy, 1); // Front triangle still in flight.
        end
        if (!rst && in_valid && in_ready) begin
            t = model_normalize(model_transform(in_triangle, cur_matrix));
            accepted++;
            if (model_is_front(t)) begin
                exp_q.push_back(t);
                accept_q.push_back(cycle);
                pushed++;
            end else begin
                exp_culls++;
            end
        end
        if (!rst && out_valid && out_ready) begin
            out_cycles.push_back(cycle);
            delivered++;
            if (exp_q.size() == 0) begin
                $display("Unexpected triangle at the output in cycle %0d", cycle);
                errors++;
            end else begin
                check_value("out_triangle", out_triangle, exp_q.pop_front());
                lat = cycle - accept_q.pop_front();
                if (check_latency) check_value("out_valid latency", lat, 3);
            end
        end
    end

    initial begin
        geometry_pkg::affine_t m;
        bit [31:0]             rdat;
        bit [31:0]             wvals[6];
        rst = 1'b1;
        in_valid = 1'b0;
        in_triangle = '0;
        out_ready = 1'b1;
        wb_req = '0;
        cur_matrix = '{m00: 32'sh10000, m11: 32'sh10000, default: '0};
        repeat (10) @(negedge clk);
        rst = 1'b0;

        check_value("out_valid", out_valid, 0);
        check_value("busy", busy, 0);
        check_value("in_ready", in_ready, 1);
        check_value("wb_rsp.ack", wb_rsp.ack, 0);
        for (int a = 0; a < 8; a++) begin
            wb_access(1'b0, 3'(a), 32'h0, rdat);
            check_value("wb_rsp.dat", rdat, (a == 0 || a == 4) ? 32'h1_0000 : 32'h0);
        end
        finish_test("reset defaults");

        for (int a = 0; a < 6; a++) begin
            wvals[a] = xorshift_next();
            wb_access(1'b1, 3'(a), wvals[a], rdat);
        end
        for (int a = 0; a < 6; a++) begin
            wb_access(1'b0, 3'(a), 32'h0, rdat);
            check_value("wb_rsp.dat", rdat, wvals[a]);
        end
        wb_access(1'b1, geometry_pkg::REG_CULL_COUNT, 32'hffff_ffff, rdat);
        wb_access(1'b0, geometry_pkg::REG_CULL_COUNT, 32'h0, rdat);
        check_value("cull_count", rdat, 0);
        finish_test("write and readback");

        for (int r = 0; r < 4; r++) begin
            m = '{m00: 32'sh10000, m11: 32'sh10000, default: '0}; // Identity first.
            if (r > 0) begin
                m.m00 = draw_fixed(65536);
                m.m01 = draw_fixed(65536);
                m.m10 = draw_fixed(65536);
                m.m11 = draw_fixed(65536);
                m.tx  = draw_fixed(32768); // Within 0.5.
                m.ty  = draw_fixed(32768);
            end
            load_matrix(m);
            send_triangles(50, 100, 100, 1'b0, 1'b1);
            wait_drain();
        end
        finish_test("affine transform stream");

        wb_access(1'b0, geometry_pkg::REG_CULL_COUNT, 32'h0, rdat);
        check_value("cull_count", rdat, exp_culls % 65536);
        finish_test("cull count");

        load_matrix('{m00: 32'sh10000, m11: 32'sh10000, default: '0});
        send_triangles(200, 60, 50, 1'b0, 1'b1);
        wait_drain();
        check_value("delivered", delivered, pushed);
        finish_test("back-pressure");

        check_latency = 1'b1;
        send_triangles(16, 50, 100, 1'b1, 1'b0);
        wait_drain();
        out_cycles.delete();
        send_triangles(8, 100, 100, 1'b1, 1'b0); // Back to back.
        wait_drain();
        check_value("burst out_valid count", out_cycles.size(), 8);
        check_value("burst out_valid span", out_cycles[out_cycles.size() - 1] - out_cycles[0], 7);
        check_latency = 1'b0;
        finish_test("latency and throughput");

        $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
        if (errors == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

    `include "geometry_model.svh"

endmodule

`default_nettype wire

/* verilog.f */
+incdir+test
source/geometry_pkg.sv
source/transform_regs.sv
source/triangle_transformer.sv
source/screen_normalizer.sv
source/backface_culler.sv
source/geometry_pipeline.sv
test/geometry_pipeline_tb.sv

/* Makefile */
VERILATOR  = verilator
LINT_FLAGS = --lint-only --timing
SIM_FLAGS  = --binary --timing -Wno-fatal
TOP        = geometry_pipeline_tb
DUT_TOP    = geometry_pipeline
FILELIST   = verilog.f
OBJ_DIR    = obj_dir
PASS_MSG   = STATUS: PASS

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(DUT_TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
